// ==== mat_cmd_pkg.sv ====
// Write command package
// Kind of write and the port that issued it

`default_nettype none

package mat_cmd_pkg;

  // ====================
  // Write kind
  // ====================

  // WR_NEW picks a fresh slot and records dimensions
  // WR_SINGLE targets the port's current slot
  typedef enum logic {
    WR_NEW    = 1'b0,
    WR_SINGLE = 1'b1
  } wr_kind_t;

  // ====================
  // Write source
  // ====================

  // Loader has priority over the ALU
  typedef enum logic {
    SRC_LOADER = 1'b0,
    SRC_ALU    = 1'b1
  } wr_src_t;

endpackage

`default_nettype wire

// ==== mat_defines.svh ====
// Matrix store geometry and storage sizes
// Shared by the packages and the RTL through `include

`ifndef MAT_DEFINES_SVH
`define MAT_DEFINES_SVH

// ====================
// Matrix geometry
// ====================

// Largest matrix is 3 by 3
`define MAT_MAX_ROWS 3
`define MAT_MAX_COLS 3

// Element count of the largest matrix
`define MAT_MAX_ELEMS 9

// Element width in bits
`define MAT_DATA_W 8

// ====================
// Slot storage
// ====================

// One size class per rows x cols combination
`define MAT_SIZE_CNT 9
// Ring length per size class
`define MAT_SLOTS_PER_SIZE 2
// Size classes times ring length
`define MAT_TOTAL_SLOTS 18
// Slots times elements per slot
`define MAT_RAM_DEPTH 162

`endif

// ==== mat_dual_read_ram.sv ====
// Simple memory with one write port and two registered read ports
// Payload type is a parameter; no reset so block RAM can be inferred

`default_nettype none
`timescale 1ns/1ps

module mat_dual_read_ram #(
  parameter type       payload_t = logic [7:0],
  parameter int        DEPTH     = 16,
  localparam int       ADDR_W    = $clog2(DEPTH)
) (
  input  wire               clk,
  input  wire               we,
  input  wire  [ADDR_W-1:0] waddr,
  input  payload_t          wdata,
  input  wire  [ADDR_W-1:0] raddr_a,
  input  wire  [ADDR_W-1:0] raddr_b,
  output payload_t          rdata_a,
  output payload_t          rdata_b
);

  payload_t mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Both reads registered, read-before-write on a collision
  always_ff @(posedge clk) begin
    rdata_a <= mem[raddr_a];
    rdata_b <= mem[raddr_b];
  end

endmodule

`default_nettype wire

// ==== mat_geom_pkg.sv ====
// Matrix geometry package
// Element, index, slot id, address and dimension types

`default_nettype none

`include "mat_defines.svh"

package mat_geom_pkg;

  // One stored element
  typedef logic [`MAT_DATA_W-1:0] elem_t;

  // Row and column index, also used for a dimension (1..3)
  typedef logic [$clog2(`MAT_MAX_ROWS + 1)-1:0] row_idx_t;
  typedef logic [$clog2(`MAT_MAX_COLS + 1)-1:0] col_idx_t;

  // Slot number across all size classes
  typedef logic [$clog2(`MAT_TOTAL_SLOTS)-1:0] mat_id_t;

  // Address into the element store
  typedef logic [$clog2(`MAT_RAM_DEPTH)-1:0] ram_addr_t;

  // Dimensions of one slot, kept together in the dimension store
  typedef struct packed {
    row_idx_t rows;
    col_idx_t cols;
  } dims_t;

endpackage

`default_nettype wire

// ==== mat_read_port.sv ====
// Read port address and flag stage
// Turns id, row and col into a store address and
// registers the slot valid flag to match the RAM latency

`default_nettype none
`timescale 1ns/1ps

`include "mat_defines.svh"

module mat_read_port (
  input  wire                          clk,
  input  wire                          rst_n,
  input  mat_geom_pkg::mat_id_t        id,
  input  mat_geom_pkg::row_idx_t       row,
  input  mat_geom_pkg::col_idx_t       col,
  input  wire [`MAT_TOTAL_SLOTS-1:0]   valid_vec,
  output mat_geom_pkg::ram_addr_t      elem_addr,
  output mat_geom_pkg::mat_id_t        meta_id,
  output logic                         valid
);

  logic id_in_range;

  // Slot base plus row-major offset
  assign elem_addr = mat_geom_pkg::ram_addr_t'(id * `MAT_MAX_ELEMS
                                               + row * `MAT_MAX_COLS + col);

  // Dimension store is indexed by slot
  assign meta_id = id;

  // Ids past the last slot never read as valid
  assign id_in_range = (id < mat_geom_pkg::mat_id_t'(`MAT_TOTAL_SLOTS));

  // Lines up with the synchronous RAM data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= id_in_range && valid_vec[id];
    end
  end

endmodule

`default_nettype wire

// ==== mat_slot_alloc.sv ====
// Slot allocator for the matrix store
// Ring pointer per size class, one current slot per writer,
// valid flags, matrix count and the store write addresses

`default_nettype none
`timescale 1ns/1ps

`include "mat_defines.svh"

module mat_slot_alloc (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  clear,
  input  wire                                  commit,
  input  mat_cmd_pkg::wr_src_t                 src,
  input  mat_cmd_pkg::wr_kind_t                kind,
  input  mat_geom_pkg::row_idx_t               dims_r,
  input  mat_geom_pkg::col_idx_t               dims_c,
  input  mat_geom_pkg::row_idx_t               row,
  input  mat_geom_pkg::col_idx_t               col,
  output logic                                 elem_we,
  output mat_geom_pkg::ram_addr_t              elem_waddr,
  output logic                                 meta_we,
  output mat_geom_pkg::mat_id_t                meta_wid,
  output mat_geom_pkg::mat_id_t                ld_dst_id,
  output mat_geom_pkg::mat_id_t                alu_dst_id,
  output logic [`MAT_TOTAL_SLOTS-1:0]          valid_vec,
  output mat_geom_pkg::mat_id_t                total_cnt
);

  localparam int TYPE_W = $clog2(`MAT_SIZE_CNT);
  localparam int PTR_W  = $clog2(`MAT_SLOTS_PER_SIZE);

  // ====================
  // Allocation
  // ====================

  logic [PTR_W-1:0]             ring_ptr [`MAT_SIZE_CNT];
  logic [TYPE_W-1:0]            type_idx;
  logic [PTR_W-1:0]             cur_ptr;
  mat_geom_pkg::mat_id_t        new_id;
  mat_geom_pkg::mat_id_t        ld_cur;
  mat_geom_pkg::mat_id_t        alu_cur;
  mat_geom_pkg::mat_id_t        target_id;
  logic [`MAT_TOTAL_SLOTS-1:0]  valid_q;
  logic                         is_new;

  // Size class from the dimensions, row major over rows x cols
  assign type_idx = TYPE_W'((int'(dims_r) - 1) * `MAT_MAX_COLS + (int'(dims_c) - 1));
  assign cur_ptr  = ring_ptr[type_idx];
  assign new_id   = mat_geom_pkg::mat_id_t'(type_idx * `MAT_SLOTS_PER_SIZE + cur_ptr);
  assign is_new   = (kind == mat_cmd_pkg::WR_NEW);

  // New writes go to the fresh slot, single writes to the port's own slot
  always_comb begin
    if (is_new) begin
      target_id = new_id;
    end else if (src == mat_cmd_pkg::SRC_ALU) begin
      target_id = alu_cur;
    end else begin
      target_id = ld_cur;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= '0;
      total_cnt <= '0;
      ld_cur    <= '0;
      alu_cur   <= '0;
      for (int i = 0; i < `MAT_SIZE_CNT; i++) begin
        ring_ptr[i] <= '0;
      end
    end else if (clear) begin
      // Drop every slot and restart every ring
      valid_q   <= '0;
      total_cnt <= '0;
      for (int i = 0; i < `MAT_SIZE_CNT; i++) begin
        ring_ptr[i] <= '0;
      end
    end else if (commit && is_new) begin
      valid_q[new_id] <= 1'b1;
      // Count only slots that were empty
      if (!valid_q[new_id]) begin
        total_cnt <= total_cnt + 1'b1;
      end
      // Advance the ring, wrap at the last slot
      if (cur_ptr == PTR_W'(`MAT_SLOTS_PER_SIZE - 1)) begin
        ring_ptr[type_idx] <= '0;
      end else begin
        ring_ptr[type_idx] <= cur_ptr + 1'b1;
      end
      if (src == mat_cmd_pkg::SRC_ALU) begin
        alu_cur <= new_id;
      end else begin
        ld_cur <= new_id;
      end
    end
  end

  // ====================
  // Store write side
  // ====================

  assign elem_we    = commit;
  assign elem_waddr = mat_geom_pkg::ram_addr_t'(target_id * `MAT_MAX_ELEMS
                                                + row * `MAT_MAX_COLS + col);
  // Dimensions are written only when a slot is opened
  assign meta_we    = commit && is_new;
  assign meta_wid   = new_id;

  assign ld_dst_id  = ld_cur;
  assign alu_dst_id = alu_cur;
  assign valid_vec  = valid_q;

endmodule

`default_nettype wire

// ==== mat_store_top.sv ====
// Matrix store top level
// Arbitrated writes from loader and ALU, slot allocation,
// element and dimension stores, two one-cycle read ports

`default_nettype none
`timescale 1ns/1ps

`include "mat_defines.svh"

module mat_store_top (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            clear,
  // Loader writer
  input  wire                            ld_req,
  input  mat_cmd_pkg::wr_kind_t          ld_kind,
  input  mat_geom_pkg::row_idx_t         ld_dims_r,
  input  mat_geom_pkg::col_idx_t         ld_dims_c,
  input  mat_geom_pkg::row_idx_t         ld_row,
  input  mat_geom_pkg::col_idx_t         ld_col,
  input  mat_geom_pkg::elem_t            ld_val,
  output logic                           ld_ack,
  output mat_geom_pkg::mat_id_t          ld_dst_id,
  // ALU writer
  input  wire                            alu_req,
  input  mat_cmd_pkg::wr_kind_t          alu_kind,
  input  mat_geom_pkg::row_idx_t         alu_dims_r,
  input  mat_geom_pkg::col_idx_t         alu_dims_c,
  input  mat_geom_pkg::row_idx_t         alu_row,
  input  mat_geom_pkg::col_idx_t         alu_col,
  input  mat_geom_pkg::elem_t            alu_val,
  output logic                           alu_ack,
  output mat_geom_pkg::mat_id_t          alu_dst_id,
  // Read port A
  input  mat_geom_pkg::mat_id_t          rd_a_id,
  input  mat_geom_pkg::row_idx_t         rd_a_row,
  input  mat_geom_pkg::col_idx_t         rd_a_col,
  output mat_geom_pkg::elem_t            rd_a_val,
  output mat_geom_pkg::row_idx_t         rd_a_dims_r,
  output mat_geom_pkg::col_idx_t         rd_a_dims_c,
  output logic                           rd_a_valid,
  // Read port B
  input  mat_geom_pkg::mat_id_t          rd_b_id,
  input  mat_geom_pkg::row_idx_t         rd_b_row,
  input  mat_geom_pkg::col_idx_t         rd_b_col,
  output mat_geom_pkg::elem_t            rd_b_val,
  output mat_geom_pkg::row_idx_t         rd_b_dims_r,
  output mat_geom_pkg::col_idx_t         rd_b_dims_c,
  output logic                           rd_b_valid,
  // Occupancy
  output mat_geom_pkg::mat_id_t          total_cnt
);

  // ====================
  // Write path
  // ====================

  logic                         grant_valid;
  mat_cmd_pkg::wr_src_t         grant_src;
  mat_cmd_pkg::wr_kind_t        sel_kind;
  mat_geom_pkg::row_idx_t       sel_dims_r;
  mat_geom_pkg::col_idx_t       sel_dims_c;
  mat_geom_pkg::row_idx_t       sel_row;
  mat_geom_pkg::col_idx_t       sel_col;
  mat_geom_pkg::elem_t          sel_val;
  mat_geom_pkg::dims_t          sel_dims;
  logic                         elem_we;
  mat_geom_pkg::ram_addr_t      elem_waddr;
  logic                         meta_we;
  mat_geom_pkg::mat_id_t        meta_wid;
  logic [`MAT_TOTAL_SLOTS-1:0]  valid_vec;

  mat_write_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .ld_req      (ld_req),
    .alu_req     (alu_req),
    .ld_ack      (ld_ack),
    .alu_ack     (alu_ack),
    .grant_valid (grant_valid),
    .grant_src   (grant_src)
  );

  // Fields of the port that owns the store
  always_comb begin
    if (grant_src == mat_cmd_pkg::SRC_ALU) begin
      sel_kind   = alu_kind;
      sel_dims_r = alu_dims_r;
      sel_dims_c = alu_dims_c;
      sel_row    = alu_row;
      sel_col    = alu_col;
      sel_val    = alu_val;
    end else begin
      sel_kind   = ld_kind;
      sel_dims_r = ld_dims_r;
      sel_dims_c = ld_dims_c;
      sel_row    = ld_row;
      sel_col    = ld_col;
      sel_val    = ld_val;
    end
  end

  assign sel_dims = '{rows: sel_dims_r, cols: sel_dims_c};

  mat_slot_alloc u_alloc (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (clear),
    .commit     (grant_valid),
    .src        (grant_src),
    .kind       (sel_kind),
    .dims_r     (sel_dims_r),
    .dims_c     (sel_dims_c),
    .row        (sel_row),
    .col        (sel_col),
    .elem_we    (elem_we),
    .elem_waddr (elem_waddr),
    .meta_we    (meta_we),
    .meta_wid   (meta_wid),
    .ld_dst_id  (ld_dst_id),
    .alu_dst_id (alu_dst_id),
    .valid_vec  (valid_vec),
    .total_cnt  (total_cnt)
  );

  // ====================
  // Stores and reads
  // ====================

  mat_geom_pkg::ram_addr_t  rd_a_addr;
  mat_geom_pkg::ram_addr_t  rd_b_addr;
  mat_geom_pkg::mat_id_t    rd_a_mid;
  mat_geom_pkg::mat_id_t    rd_b_mid;
  mat_geom_pkg::dims_t      rd_a_dims;
  mat_geom_pkg::dims_t      rd_b_dims;

  mat_read_port u_rd_a (
    .clk       (clk),
    .rst_n     (rst_n),
    .id        (rd_a_id),
    .row       (rd_a_row),
    .col       (rd_a_col),
    .valid_vec (valid_vec),
    .elem_addr (rd_a_addr),
    .meta_id   (rd_a_mid),
    .valid     (rd_a_valid)
  );

  mat_read_port u_rd_b (
    .clk       (clk),
    .rst_n     (rst_n),
    .id        (rd_b_id),
    .row       (rd_b_row),
    .col       (rd_b_col),
    .valid_vec (valid_vec),
    .elem_addr (rd_b_addr),
    .meta_id   (rd_b_mid),
    .valid     (rd_b_valid)
  );

  // Element store, one entry per slot element
  mat_dual_read_ram #(
    .payload_t (mat_geom_pkg::elem_t),
    .DEPTH     (`MAT_RAM_DEPTH)
  ) u_elem_ram (
    .clk     (clk),
    .we      (elem_we),
    .waddr   (elem_waddr),
    .wdata   (sel_val),
    .raddr_a (rd_a_addr),
    .raddr_b (rd_b_addr),
    .rdata_a (rd_a_val),
    .rdata_b (rd_b_val)
  );

  // Dimension store, one entry per slot
  mat_dual_read_ram #(
    .payload_t (mat_geom_pkg::dims_t),
    .DEPTH     (`MAT_TOTAL_SLOTS)
  ) u_meta_ram (
    .clk     (clk),
    .we      (meta_we),
    .waddr   (meta_wid),
    .wdata   (sel_dims),
    .raddr_a (rd_a_mid),
    .raddr_b (rd_b_mid),
    .rdata_a (rd_a_dims),
    .rdata_b (rd_b_dims)
  );

  assign rd_a_dims_r = rd_a_dims.rows;
  assign rd_a_dims_c = rd_a_dims.cols;
  assign rd_b_dims_r = rd_b_dims.rows;
  assign rd_b_dims_c = rd_b_dims.cols;

endmodule

`default_nettype wire

// ==== mat_write_arbiter.sv ====
// Write arbiter for the matrix store
// Four-phase req/ack front end for the loader and ALU writers
// Fixed priority, loader first; one commit pulse per granted write

`default_nettype none
`timescale 1ns/1ps

module mat_write_arbiter (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  clear,
  input  wire                  ld_req,
  input  wire                  alu_req,
  output logic                 ld_ack,
  output logic                 alu_ack,
  output logic                 grant_valid,
  output mat_cmd_pkg::wr_src_t grant_src
);

  // ====================
  // State
  // ====================

  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_COMMIT   = 2'd1,
    ST_WAIT_REL = 2'd2,
    ST_RELEASE  = 2'd3
  } state_t;

  state_t               state;
  mat_cmd_pkg::wr_src_t owner;
  logic                 owner_req;
  logic                 ack_phase;

  // Request line of whoever holds the store
  assign owner_req = (owner == mat_cmd_pkg::SRC_ALU) ? alu_req : ld_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      owner <= mat_cmd_pkg::SRC_LOADER;
    end else begin
      case (state)
        ST_IDLE: begin
          // Loader wins a tie
          if (ld_req) begin
            owner <= mat_cmd_pkg::SRC_LOADER;
            state <= ST_COMMIT;
          end else if (alu_req) begin
            owner <= mat_cmd_pkg::SRC_ALU;
            state <= ST_COMMIT;
          end
        end
        ST_COMMIT: begin
          // A clear in this cycle pushes the commit out by one cycle
          if (!clear) begin
            state <= ST_WAIT_REL;
          end
        end
        ST_WAIT_REL: begin
          // Hold ack until the writer drops req
          if (!owner_req) begin
            state <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ====================
  // Outputs
  // ====================

  // Single-cycle write strobe, held back by clear
  assign grant_valid = (state == ST_COMMIT) && !clear;
  assign grant_src   = owner;

  // ack is up from the commit edge until the release state is left
  assign ack_phase = (state == ST_WAIT_REL) || (state == ST_RELEASE);
  assign ld_ack    = ack_phase && (owner == mat_cmd_pkg::SRC_LOADER);
  assign alu_ack   = ack_phase && (owner == mat_cmd_pkg::SRC_ALU);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the matrix store testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f \
  --top-module tb_mat_store \
  -Mdir obj_dir \
  -o tb_mat_store

# $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_mat_store

// ==== sources.f ====
+incdir+.
mat_geom_pkg.sv
mat_cmd_pkg.sv
mat_write_arbiter.sv
mat_slot_alloc.sv
mat_dual_read_ram.sv
mat_read_port.sv
mat_store_top.sv
tb_mat_store.sv

// ==== tb_mat_store.sv ====
// Testbench for the matrix store
// Two writer processes on the four-phase ports, a storage model,
// read sweeps on both read ports and a watchdog

`default_nettype none
`timescale 1ns/1ps

`include "mat_defines.svh"

module tb_mat_store;

  localparam int ROUNDS        = 3;
  localparam int TXN_PER_PORT  = 40;
  localparam int TIE_PAIRS     = 4;
  localparam int RANDOM_READS  = 20;
  localparam int SWEEP_READS   = `MAT_TOTAL_SLOTS * `MAT_MAX_ELEMS;
  localparam int PLANNED_TXN   = RANDOM_READS + ROUNDS * (`MAT_SIZE_CNT + 2 * TIE_PAIRS
                                 + 2 * TXN_PER_PORT + 2 * SWEEP_READS);
  localparam int WATCHDOG_CYC  = 16 + PLANNED_TXN * 200;

  // ====================
  // DUT signals
  // ====================

  logic clk = 1'b0;
  logic rst_n, clear;
  logic ld_req, alu_req, ld_ack, alu_ack;
  mat_cmd_pkg::wr_kind_t   ld_kind, alu_kind;
  mat_geom_pkg::row_idx_t  ld_dims_r, alu_dims_r, ld_row, alu_row;
  mat_geom_pkg::col_idx_t  ld_dims_c, alu_dims_c, ld_col, alu_col;
  mat_geom_pkg::elem_t     ld_val, alu_val;
  mat_geom_pkg::mat_id_t   ld_dst_id, alu_dst_id, total_cnt;
  mat_geom_pkg::mat_id_t   rd_a_id, rd_b_id;
  mat_geom_pkg::row_idx_t  rd_a_row, rd_b_row, rd_a_dims_r, rd_b_dims_r;
  mat_geom_pkg::col_idx_t  rd_a_col, rd_b_col, rd_a_dims_c, rd_b_dims_c;
  mat_geom_pkg::elem_t     rd_a_val, rd_b_val;
  logic                    rd_a_valid, rd_b_valid;

  mat_store_top i_dut (
    .clk(clk), .rst_n(rst_n), .clear(clear),
    .ld_req(ld_req), .ld_kind(ld_kind), .ld_dims_r(ld_dims_r), .ld_dims_c(ld_dims_c),
    .ld_row(ld_row), .ld_col(ld_col), .ld_val(ld_val),
    .ld_ack(ld_ack), .ld_dst_id(ld_dst_id),
    .alu_req(alu_req), .alu_kind(alu_kind), .alu_dims_r(alu_dims_r),
    .alu_dims_c(alu_dims_c), .alu_row(alu_row), .alu_col(alu_col), .alu_val(alu_val),
    .alu_ack(alu_ack), .alu_dst_id(alu_dst_id),
    .rd_a_id(rd_a_id), .rd_a_row(rd_a_row), .rd_a_col(rd_a_col),
    .rd_a_val(rd_a_val), .rd_a_dims_r(rd_a_dims_r), .rd_a_dims_c(rd_a_dims_c),
    .rd_a_valid(rd_a_valid),
    .rd_b_id(rd_b_id), .rd_b_row(rd_b_row), .rd_b_col(rd_b_col),
    .rd_b_val(rd_b_val), .rd_b_dims_r(rd_b_dims_r), .rd_b_dims_c(rd_b_dims_c),
    .rd_b_valid(rd_b_valid),
    .total_cnt(total_cnt)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ====================
  // Storage model
  // ====================

  int m_ptr   [`MAT_SIZE_CNT];
  bit m_valid [`MAT_TOTAL_SLOTS];
  bit m_dknown[`MAT_TOTAL_SLOTS];
  int m_dims_r[`MAT_TOTAL_SLOTS];
  int m_dims_c[`MAT_TOTAL_SLOTS];
  int m_elem  [`MAT_RAM_DEPTH];
  bit m_known [`MAT_RAM_DEPTH];
  int m_cur   [2];
  int m_cnt;
  int last_id [2];
  int ack_order[$];

  // Handshake monitor history
  logic ld_ack_q, alu_ack_q, ld_req_q, alu_req_q;

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
               $time, name, got, expected);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // Slot is the size class times 2 plus the ring pointer of that class
  task automatic model_commit(input int p, input bit is_new, input int dr, input int dc,
                              input int r, input int c, input int v, output int id);
    int t;
    int addr;
    if (is_new) begin
      t = (dr - 1) * `MAT_MAX_COLS + (dc - 1);
      id = t * `MAT_SLOTS_PER_SIZE + m_ptr[t];
      m_ptr[t] = (m_ptr[t] + 1) % `MAT_SLOTS_PER_SIZE;
      if (!m_valid[id]) m_cnt++;
      m_valid[id]  = 1'b1;
      m_dknown[id] = 1'b1;
      m_dims_r[id] = dr;
      m_dims_c[id] = dc;
      m_cur[p]     = id;
    end else begin
      id = m_cur[p];
    end
    addr = id * `MAT_MAX_ELEMS + r * `MAT_MAX_COLS + c;
    m_elem[addr]  = v;
    m_known[addr] = 1'b1;
  endtask

  // Contents stay in the stores while flags, count and rings restart
  task automatic model_clear();
    for (int i = 0; i < `MAT_SIZE_CNT; i++) m_ptr[i] = 0;
    for (int i = 0; i < `MAT_TOTAL_SLOTS; i++) m_valid[i] = 1'b0;
    m_cnt = 0;
  endtask

  // ====================
  // Writer side
  // ====================

  task automatic drive_writer(input int p, input mat_cmd_pkg::wr_kind_t kind,
                              input int dr, input int dc, input int r, input int c,
                              input int v);
    if (p == 0) begin
      ld_req    <= 1'b1;
      ld_kind   <= kind;
      ld_dims_r <= mat_geom_pkg::row_idx_t'(dr);
      ld_dims_c <= mat_geom_pkg::col_idx_t'(dc);
      ld_row    <= mat_geom_pkg::row_idx_t'(r);
      ld_col    <= mat_geom_pkg::col_idx_t'(c);
      ld_val    <= mat_geom_pkg::elem_t'(v);
    end else begin
      alu_req    <= 1'b1;
      alu_kind   <= kind;
      alu_dims_r <= mat_geom_pkg::row_idx_t'(dr);
      alu_dims_c <= mat_geom_pkg::col_idx_t'(dc);
      alu_row    <= mat_geom_pkg::row_idx_t'(r);
      alu_col    <= mat_geom_pkg::col_idx_t'(c);
      alu_val    <= mat_geom_pkg::elem_t'(v);
    end
  endtask

  // Sampled on the falling edge away from the driving edge
  task automatic wait_ack(input int p, input logic level);
    do begin
      @(negedge clk);
    end while (((p == 0) ? ld_ack : alu_ack) !== level);
  endtask

  // One full four-phase transaction
  task automatic write_txn(input int p, input bit is_new, input int dr, input int dc);
    mat_cmd_pkg::wr_kind_t kind;
    int r;
    int c;
    int v;
    int exp_id;
    int got_id;
    string id_name;
    kind = is_new ? mat_cmd_pkg::WR_NEW : mat_cmd_pkg::WR_SINGLE;
    r = int'($urandom_range(2, 0));
    c = int'($urandom_range(2, 0));
    v = int'($urandom_range(255, 0));
    @(posedge clk);
    drive_writer(p, kind, dr, dc, r, c, v);
    wait_ack(p, 1'b1);
    ack_order.push_back(p);
    model_commit(p, is_new, dr, dc, r, c, v, exp_id);
    // dst_id is taken while ack is high
    if (p == 0) begin
      id_name = "ld_dst_id";
      got_id  = int'(ld_dst_id);
    end else begin
      id_name = "alu_dst_id";
      got_id  = int'(alu_dst_id);
    end
    last_id[p] = got_id;
    check_eq(id_name, 32'(got_id), 32'(exp_id));
    check_eq("total_cnt", 32'(total_cnt), 32'(m_cnt));
    @(posedge clk);
    if (p == 0) ld_req <= 1'b0;
    else alu_req <= 1'b0;
    wait_ack(p, 1'b0);
  endtask

  task automatic random_writer(input int p, input int n);
    for (int i = 0; i < n; i++) begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      write_txn(p, $urandom_range(1, 0) == 0,
                int'($urandom_range(3, 1)), int'($urandom_range(3, 1)));
    end
  endtask

  // Both ports request on the same edge and the loader goes first
  task automatic tie_pair();
    ack_order.delete();
    fork
      write_txn(0, 1'b1, int'($urandom_range(3, 1)), int'($urandom_range(3, 1)));
      write_txn(1, 1'b1, int'($urandom_range(3, 1)), int'($urandom_range(3, 1)));
    join
    check_eq("first ack source", 32'(ack_order[0]), 32'd0);
  endtask

  // First new write of every size class lands in slot class*2
  task automatic class_writes(input int p);
    for (int t = 0; t < `MAT_SIZE_CNT; t++) begin
      write_txn(p, 1'b1, t / `MAT_MAX_COLS + 1, t % `MAT_MAX_COLS + 1);
      check_eq("first slot of class", 32'(last_id[p]), 32'(t * `MAT_SLOTS_PER_SIZE));
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    model_clear();
    @(negedge clk);
    check_eq("total_cnt", 32'(total_cnt), 32'd0);
  endtask

  // ====================
  // Read side
  // ====================

  task automatic check_read(input int port, input int id, input int r, input int c);
    logic vld;
    logic [7:0] val;
    logic [1:0] dr;
    logic [1:0] dc;
    int addr;
    string pfx;
    pfx  = (port == 0) ? "rd_a" : "rd_b";
    vld  = (port == 0) ? rd_a_valid : rd_b_valid;
    val  = (port == 0) ? rd_a_val : rd_b_val;
    dr   = (port == 0) ? rd_a_dims_r : rd_b_dims_r;
    dc   = (port == 0) ? rd_a_dims_c : rd_b_dims_c;
    addr = id * `MAT_MAX_ELEMS + r * `MAT_MAX_COLS + c;
    check_eq({pfx, "_valid"}, 32'(vld), 32'(m_valid[id]));
    if (m_dknown[id]) begin
      check_eq({pfx, "_dims_r"}, 32'(dr), 32'(m_dims_r[id]));
      check_eq({pfx, "_dims_c"}, 32'(dc), 32'(m_dims_c[id]));
    end
    // Never written elements hold no defined value
    if (m_known[addr]) check_eq({pfx, "_val"}, 32'(val), 32'(m_elem[addr]));
  endtask

  // Address on one edge and data checked after the next one
  task automatic read_pair(input int ida, input int ra, input int ca,
                           input int idb, input int rb, input int cb);
    @(posedge clk);
    rd_a_id  <= mat_geom_pkg::mat_id_t'(ida);
    rd_a_row <= mat_geom_pkg::row_idx_t'(ra);
    rd_a_col <= mat_geom_pkg::col_idx_t'(ca);
    rd_b_id  <= mat_geom_pkg::mat_id_t'(idb);
    rd_b_row <= mat_geom_pkg::row_idx_t'(rb);
    rd_b_col <= mat_geom_pkg::col_idx_t'(cb);
    @(posedge clk);
    @(negedge clk);
    check_read(0, ida, ra, ca);
    check_read(1, idb, rb, cb);
  endtask

  // Every element of every slot with port B half the store away
  task automatic sweep_store();
    int e2;
    for (int id = 0; id < `MAT_TOTAL_SLOTS; id++) begin
      for (int e = 0; e < `MAT_MAX_ELEMS; e++) begin
        e2 = (e + 4) % `MAT_MAX_ELEMS;
        read_pair(id, e / 3, e % 3, (id + 9) % `MAT_TOTAL_SLOTS, e2 / 3, e2 % 3);
      end
    end
  endtask

  // ====================
  // Handshake monitor
  // ====================

  always @(negedge clk) begin
    if (rst_n) begin
      check_eq("ld_ack and alu_ack together", 32'(ld_ack && alu_ack), 32'd0);
      if (ld_ack_q && ld_req_q) check_eq("ld_ack held", 32'(ld_ack), 32'd1);
      if (alu_ack_q && alu_req_q) check_eq("alu_ack held", 32'(alu_ack), 32'd1);
    end
    ld_ack_q  = ld_ack;
    alu_ack_q = alu_ack;
    ld_req_q  = ld_req;
    alu_req_q = alu_req;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  // ====================
  // Main sequence
  // ====================

  initial begin : main
    void'($urandom(32'ha85133ac));
    rst_n      = 1'b0;
    clear      = 1'b0;
    ld_req     = 1'b0;
    ld_kind    = mat_cmd_pkg::WR_NEW;
    ld_dims_r  = mat_geom_pkg::row_idx_t'(1);
    ld_dims_c  = mat_geom_pkg::col_idx_t'(1);
    ld_row     = '0;
    ld_col     = '0;
    ld_val     = '0;
    alu_req    = 1'b0;
    alu_kind   = mat_cmd_pkg::WR_NEW;
    alu_dims_r = mat_geom_pkg::row_idx_t'(1);
    alu_dims_c = mat_geom_pkg::col_idx_t'(1);
    alu_row    = '0;
    alu_col    = '0;
    alu_val    = '0;
    rd_a_id    = '0;
    rd_a_row   = '0;
    rd_a_col   = '0;
    rd_b_id    = '0;
    rd_b_row   = '0;
    rd_b_col   = '0;
    for (int i = 0; i < `MAT_RAM_DEPTH; i++) m_known[i] = 1'b0;
    for (int i = 0; i < `MAT_TOTAL_SLOTS; i++) m_dknown[i] = 1'b0;
    m_cur[0] = 0;
    m_cur[1] = 0;
    model_clear();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Empty store after reset
    @(negedge clk);
    check_eq("total_cnt", 32'(total_cnt), 32'd0);
    repeat (RANDOM_READS) begin
      read_pair(int'($urandom_range(17, 0)), int'($urandom_range(2, 0)),
                int'($urandom_range(2, 0)), int'($urandom_range(17, 0)),
                int'($urandom_range(2, 0)), int'($urandom_range(2, 0)));
    end

    for (int rnd = 0; rnd < ROUNDS; rnd++) begin
      if (rnd > 0) begin
        pulse_clear();
        sweep_store();
      end
      class_writes(rnd % 2);
      repeat (TIE_PAIRS) tie_pair();
      fork
        random_writer(0, TXN_PER_PORT);
        random_writer(1, TXN_PER_PORT);
      join
      sweep_store();
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
